//--- common/ads_bus_pkg.sv
`include "ads_defs.svh"

package ads_bus_pkg;

    // Full bus address
    // Layout is {2'b00, slave select, offset}
    typedef logic [`ADS_ADDR_W-1:0] addr_t;

    // One data byte
    typedef logic [`ADS_DATA_W-1:0] data_t;

    // Slave number
    typedef logic [`ADS_SLAVE_SEL_W-1:0] slave_sel_t;

    // Index into a slave memory
    // Low bits of the offset field
    typedef logic [`ADS_MEM_AW-1:0] mem_idx_t;

endpackage

//--- common/ads_defs.svh
`ifndef ADS_DEFS_SVH
`define ADS_DEFS_SVH

// ==============================
// Bus geometry
// ==============================
`define ADS_ADDR_W       16
`define ADS_DATA_W       8
`define ADS_NUM_SLAVES   3
`define ADS_SLAVE_SEL_W  2
// 16 bytes per slave
`define ADS_MEM_AW       4
`define ADS_OFFSET_W     12

// ==============================
// Demo constants
// ==============================
`define ADS_DEMO_OFFSET  12'h010
`define ADS_INIT_PATTERN 8'h00
`define ADS_SYNC_STAGES  2

`endif

//--- common/ads_demo_pkg.sv
package ads_demo_pkg;

    // Transaction controller states
    typedef enum logic [2:0] {
        DEMO_IDLE     = 3'd0,
        DEMO_START    = 3'd1,
        DEMO_WAIT     = 3'd2,
        DEMO_COMPLETE = 3'd3,
        DEMO_DISPLAY  = 3'd4
    } demo_state_e;

    // Bus direction
    // 1 is write, 0 is read
    typedef logic bus_mode_t;

endpackage

//--- fabric/response_mux.sv
`timescale 1ns/1ps
`include "ads_defs.svh"

module response_mux (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  logic [`ADS_NUM_SLAVES-1:0]                    valid,
    input  logic [`ADS_NUM_SLAVES-1:0]                    ready,
    input  ads_bus_pkg::data_t [`ADS_NUM_SLAVES-1:0]      rdata,
    output logic                                          done,
    output ads_bus_pkg::data_t                            rd_data
);
    import ads_bus_pkg::*;

    // Slave with the request outstanding
    slave_sel_t sel_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sel_q <= '0;
        end else begin
            // At most one valid bit is set
            for (int i = 0; i < `ADS_NUM_SLAVES; i++) begin
                if (valid[i]) begin
                    sel_q <= slave_sel_t'(i);
                end
            end
        end
    end

    // Pass through from the latched slave
    assign done    = ready[sel_q];
    assign rd_data = rdata[sel_q];

endmodule

//--- fabric/slave_decoder.sv
`timescale 1ns/1ps
`include "ads_defs.svh"

module slave_decoder (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       req,
    input  ads_bus_pkg::addr_t         req_addr,
    input  ads_bus_pkg::data_t         req_wdata,
    input  ads_demo_pkg::bus_mode_t    req_mode,
    output logic [`ADS_NUM_SLAVES-1:0] valid,
    output ads_bus_pkg::mem_idx_t      mem_idx,
    output ads_bus_pkg::data_t         wdata,
    output ads_demo_pkg::bus_mode_t    mode
);
    import ads_bus_pkg::*;

    slave_sel_t sel;

    // Select field sits just above the offset
    assign sel = req_addr[`ADS_OFFSET_W +: `ADS_SLAVE_SEL_W];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else begin
            valid <= '0;
            // Unmapped select values are ignored
            if (req && (int'(sel) < `ADS_NUM_SLAVES)) begin
                valid[sel] <= 1'b1;
            end
        end
    end

    // Shared request fields for all slaves
    always_ff @(posedge clk) begin
        if (req) begin
            mem_idx <= req_addr[`ADS_MEM_AW-1:0];
            wdata   <= req_wdata;
            mode    <= req_mode;
        end
    end

    // Bits above the select field are not decoded, so they must be zero
    a_addr_pad_zero: assert property (
        @(posedge clk) disable iff (!rstn)
            req |-> (req_addr[`ADS_ADDR_W-1:`ADS_OFFSET_W+`ADS_SLAVE_SEL_W] == '0)
    );

endmodule

//--- fabric/slave_memory.sv
`timescale 1ns/1ps
`include "ads_defs.svh"

module slave_memory #(
    parameter int MEM_AW = `ADS_MEM_AW
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    valid,
    input  logic [MEM_AW-1:0]       mem_idx,
    input  ads_bus_pkg::data_t      wdata,
    input  ads_demo_pkg::bus_mode_t mode,
    output logic                    ready,
    output ads_bus_pkg::data_t      rdata
);
    import ads_bus_pkg::*;

    localparam int DEPTH = 2 ** MEM_AW;

    data_t mem [DEPTH];

    // ==============================
    // Storage and response
    // ==============================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            // Memory reads as zero after reset
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            ready <= 1'b0;
            rdata <= '0;
        end else begin
            // One cycle latency for every access
            ready <= valid;
            if (valid) begin
                if (mode == 1'b1) begin
                    mem[mem_idx] <= wdata;
                end else begin
                    rdata <= mem[mem_idx];
                end
            end
        end
    end

    // One request in flight, so valid is a single cycle pulse
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!rstn) valid |=> !valid
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_ads_bus_demo -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -F "** PASS **" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim.f
+incdir+common
common/ads_bus_pkg.sv
common/ads_demo_pkg.sv
src/panel_inputs.sv
src/demo_controller.sv
fabric/slave_decoder.sv
fabric/slave_memory.sv
fabric/response_mux.sv
src/ads_bus_demo.sv
test/led_checker.sv
test/tb_ads_bus_demo.sv

//--- src/ads_bus_demo.sv
`timescale 1ns/1ps
`include "ads_defs.svh"

module ads_bus_demo (
    input  logic       clk,
    input  logic       rstn,
    input  logic [1:0] key,
    input  logic [3:0] sw,
    output logic [7:0] led
);
    import ads_bus_pkg::*;
    import ads_demo_pkg::*;

    // Panel to controller
    logic       start_pulse;
    slave_sel_t slave_sel;
    bus_mode_t  mode;
    data_t      pattern;

    // Controller to decoder
    logic      req;
    addr_t     req_addr;
    data_t     req_wdata;
    bus_mode_t req_mode;

    // Decoder to slaves
    logic [`ADS_NUM_SLAVES-1:0] valid;
    mem_idx_t                   mem_idx;
    data_t                      wdata;
    bus_mode_t                  bus_mode;

    // Slaves back to the controller
    logic [`ADS_NUM_SLAVES-1:0]  ready;
    data_t [`ADS_NUM_SLAVES-1:0] rdata;
    logic                        done;
    data_t                       rd_data;

    // ==============================
    // Panel and controller
    // ==============================
    // SW[0] has no function here
    panel_inputs panel_inputs_inst (
        .clk(clk), .rstn(rstn), .key(key), .sw(sw[3:1]),
        .start_pulse(start_pulse), .slave_sel(slave_sel), .mode(mode), .pattern(pattern)
    );

    demo_controller demo_controller_inst (
        .clk(clk), .rstn(rstn), .start_pulse(start_pulse), .slave_sel(slave_sel),
        .mode(mode), .pattern(pattern), .done(done), .rd_data(rd_data), .req(req),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_mode(req_mode), .led(led)
    );

    // ==============================
    // Slave fabric
    // ==============================
    slave_decoder slave_decoder_inst (
        .clk(clk), .rstn(rstn), .req(req), .req_addr(req_addr), .req_wdata(req_wdata),
        .req_mode(req_mode), .valid(valid), .mem_idx(mem_idx), .wdata(wdata), .mode(bus_mode)
    );

    // Identical slaves
    for (genvar i = 0; i < `ADS_NUM_SLAVES; i++) begin : g_slave
        slave_memory slave_memory_inst (
            .clk(clk), .rstn(rstn), .valid(valid[i]), .mem_idx(mem_idx), .wdata(wdata),
            .mode(bus_mode), .ready(ready[i]), .rdata(rdata[i])
        );
    end

    response_mux response_mux_inst (
        .clk(clk), .rstn(rstn), .valid(valid), .ready(ready), .rdata(rdata),
        .done(done), .rd_data(rd_data)
    );

endmodule

//--- src/demo_controller.sv
`timescale 1ns/1ps
`include "ads_defs.svh"

module demo_controller (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start_pulse,
    input  ads_bus_pkg::slave_sel_t slave_sel,
    input  ads_demo_pkg::bus_mode_t mode,
    input  ads_bus_pkg::data_t      pattern,
    input  logic                    done,
    input  ads_bus_pkg::data_t      rd_data,
    output logic                    req,
    output ads_bus_pkg::addr_t      req_addr,
    output ads_bus_pkg::data_t      req_wdata,
    output ads_demo_pkg::bus_mode_t req_mode,
    output logic [7:0]              led
);
    import ads_bus_pkg::*;
    import ads_demo_pkg::*;

    localparam int PAD_W = `ADS_ADDR_W - `ADS_SLAVE_SEL_W - `ADS_OFFSET_W;

    demo_state_e state;
    slave_sel_t  cap_sel;
    bus_mode_t   cap_mode;
    data_t       rd_q;
    data_t       disp_data;

    // ==============================
    // Transaction FSM
    // ==============================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= DEMO_IDLE;
            req      <= 1'b0;
            cap_sel  <= '0;
            cap_mode <= '0;
            led      <= '0;
        end else begin
            // Request is a single cycle strobe
            req <= 1'b0;
            case (state)
                DEMO_IDLE: begin
                    // Presses elsewhere are dropped
                    if (start_pulse) begin
                        cap_sel  <= slave_sel;
                        cap_mode <= mode;
                        state    <= DEMO_START;
                    end
                end
                DEMO_START: begin
                    req   <= 1'b1;
                    state <= DEMO_WAIT;
                end
                DEMO_WAIT: begin
                    // Fixed slave latency, no timeout needed
                    if (done) begin
                        state <= DEMO_COMPLETE;
                    end
                end
                DEMO_COMPLETE: begin
                    led   <= {disp_data[5:0], cap_sel};
                    state <= DEMO_DISPLAY;
                end
                DEMO_DISPLAY: begin
                    state <= DEMO_IDLE;
                end
                default: begin
                    state <= DEMO_IDLE;
                end
            endcase
        end
    end

    // Request fields and returned byte
    always_ff @(posedge clk) begin
        if (state == DEMO_START) begin
            req_addr  <= {{PAD_W{1'b0}}, cap_sel, `ADS_DEMO_OFFSET};
            req_wdata <= pattern;
            req_mode  <= cap_mode;
        end
        if ((state == DEMO_WAIT) && done) begin
            rd_q <= rd_data;
        end
    end

    // Written byte for writes, returned byte for reads
    assign disp_data = (cap_mode == 1'b1) ? req_wdata : rd_q;

    // Only one request in flight, so done lands in WAIT
    a_done_in_wait: assert property (
        @(posedge clk) disable iff (!rstn) done |-> (state == DEMO_WAIT)
    );

endmodule

//--- src/panel_inputs.sv
`timescale 1ns/1ps
`include "ads_defs.svh"

module panel_inputs (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [1:0]              key,
    input  logic [2:0]              sw,
    output logic                    start_pulse,
    output ads_bus_pkg::slave_sel_t slave_sel,
    output ads_demo_pkg::bus_mode_t mode,
    output ads_bus_pkg::data_t      pattern
);
    import ads_bus_pkg::*;
    import ads_demo_pkg::*;

    localparam int STAGES = `ADS_SYNC_STAGES;

    // Synchronizer chains, last stage is the stable copy
    logic [STAGES-1:0][1:0] key_sync;
    logic [STAGES-1:0][2:0] sw_sync;
    logic [1:0]             key_prev;
    logic [1:0]             key_fall;
    logic [2:0]             sw_stable;

    // ==============================
    // Synchronizers
    // ==============================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            // Keys idle high when released
            key_sync <= '1;
            sw_sync  <= '0;
            key_prev <= 2'b11;
            key_fall <= 2'b00;
        end else begin
            key_sync <= {key_sync[STAGES-2:0], key};
            sw_sync  <= {sw_sync[STAGES-2:0], sw};
            key_prev <= key_sync[STAGES-1];
            // High to low on the synchronized key
            key_fall <= key_prev & ~key_sync[STAGES-1];
        end
    end

    assign start_pulse = key_fall[0];
    // Bit 0 is SW[1], kept for the old master select
    assign sw_stable   = sw_sync[STAGES-1];

    // ==============================
    // Switch decode
    // ==============================
    // Code 11 reads back slave 0
    always_comb begin
        if (sw_stable[2:1] == 2'b11) begin
            slave_sel = slave_sel_t'(0);
            mode      = bus_mode_t'(1'b0);
        end else begin
            slave_sel = slave_sel_t'(sw_stable[2:1]);
            mode      = bus_mode_t'(1'b1);
        end
    end

    // Pattern counter, one step per KEY[1] press
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pattern <= `ADS_INIT_PATTERN;
        end else if (key_fall[1]) begin
            // Wraps from FF to 00
            pattern <= pattern + data_t'(1);
        end
    end

endmodule

//--- test/led_checker.sv
`timescale 1ns/1ps

module led_checker (
    input  logic       clk,
    input  logic       check,
    input  logic [7:0] expected,
    input  logic [7:0] led,
    output int         error_count,
    output int         check_count
);

    // Running totals
    int errors = 0;
    int checks = 0;

    // ==============================
    // LED compare
    // ==============================
    // Strobe and expected value come from the stimulus loop
    always @(posedge clk) begin
        if (check) begin
            checks = checks + 1;
            // Four-state compare, X on the LED counts as wrong
            if (led !== expected) begin
                errors = errors + 1;
                $display("FAILED led: expected %h, got %h (check %0d, time %0t)",
                         expected, led, checks, $time);
            end
        end
    end

    assign error_count = errors;
    assign check_count = checks;

endmodule

//--- test/tb_ads_bus_demo.sv
`timescale 1ns/1ps
`include "ads_defs.svh"

module tb_ads_bus_demo;

    localparam int NUM_ROWS  = 12;
    localparam int NUM_FIXED = 7;

    // Directed rows
    // Read, write 1, read, write 0, write 2, read, write 0 after a full wrap
    localparam int         FIXED_PRESSES [NUM_FIXED] = '{0, 3, 0, 1, 2, 0, 256};
    localparam logic [1:0] FIXED_SEL     [NUM_FIXED] = '{2'd3, 2'd1, 2'd3, 2'd0,
                                                         2'd2, 2'd3, 2'd0};

    logic       clk;
    logic       rstn;
    logic [1:0] key;
    logic [3:0] sw;
    logic [7:0] led;

    // Checker strobe
    logic       check;
    logic [7:0] check_exp;
    int         error_count;
    int         check_count;

    // Stimulus table
    int         row_presses [NUM_ROWS];
    logic [3:0] row_sw      [NUM_ROWS];
    logic [7:0] row_exp     [NUM_ROWS];

    logic [31:0] rnd_state;
    int          cycle_count = 0;
    int          cycle_limit;

    ads_bus_demo ads_bus_demo_inst (
        .clk(clk), .rstn(rstn), .key(key), .sw(sw), .led(led)
    );

    led_checker led_checker_inst (
        .clk(clk), .check(check), .expected(check_exp), .led(led),
        .error_count(error_count), .check_count(check_count)
    );

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ==============================
    // Table and reference model
    // ==============================
    // Shadow pattern counter and one shadow byte per slave
    task automatic build_table();
        logic [7:0] pat;
        logic [7:0] shadow_mem [3];
        logic [1:0] sel;
        int         total;
        pat   = `ADS_INIT_PATTERN;
        total = 0;
        for (int s = 0; s < 3; s++) begin
            shadow_mem[s] = 8'h00;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i < NUM_FIXED) begin
                row_presses[i] = FIXED_PRESSES[i];
                sel            = FIXED_SEL[i];
                row_sw[i]      = {sel, 2'b00};
            end else begin
                rnd_state      = xorshift32(rnd_state);
                row_presses[i] = int'(rnd_state[7:0]);
                sel            = rnd_state[9:8];
                // SW[1:0] have no function, so random values there
                row_sw[i]      = {sel, rnd_state[11:10]};
            end
            // One step per press, modulo 256
            pat = pat + 8'(row_presses[i]);
            if (sel == 2'd3) begin
                // Read back slave 0
                row_exp[i] = {shadow_mem[0][5:0], 2'b00};
            end else begin
                shadow_mem[sel] = pat;
                row_exp[i]      = {pat[5:0], sel};
            end
            // Eight cycles per press plus the fixed row overhead
            total = total + row_presses[i] * 8 + 40;
        end
        cycle_limit = total + 100;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // One KEY[1] press, low 4 then high 4
    task automatic press_pattern_key();
        key[1] <= 1'b0;
        wait_cycles(4);
        key[1] <= 1'b1;
        wait_cycles(4);
    endtask

    task automatic start_transaction();
        key[0] <= 1'b0;
        wait_cycles(4);
        key[0] <= 1'b1;
    endtask

    task automatic strobe_check(input logic [7:0] value);
        check_exp <= value;
        check     <= 1'b1;
        wait_cycles(1);
        check     <= 1'b0;
    endtask

    task automatic print_totals(input int errs);
        $display("Checks: %0d, errors: %0d", check_count, errs);
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        // Keys released, switches low
        rstn      = 1'b0;
        key       = 2'b11;
        sw        = 4'h0;
        check     = 1'b0;
        check_exp = 8'h00;
        rnd_state = 32'd68;
        build_table();

        wait_cycles(2);
        rstn <= 1'b1;

        // LED idle after reset
        wait_cycles(4);
        strobe_check(8'h00);

        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int p = 0; p < row_presses[i]; p++) begin
                press_pattern_key();
            end
            sw <= row_sw[i];
            wait_cycles(4);
            start_transaction();
            wait_cycles(16);
            strobe_check(row_exp[i]);
        end

        wait_cycles(2);
        print_totals(error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            print_totals(error_count + 1);
            $display("** FAIL **");
            $finish;
        end
    end

endmodule
